/* compile.f */
design/trace_geom_pkg.sv
design/trace_fsm_pkg.sv
design/trace_shift_buffer.sv
design/unit_assembler.sv
design/replay_trace_parser.sv
sim/replay_trace_parser_sva.sv
sim/tb_replay_trace_parser.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# nonzero exit when the build fails or the simulation stops on an error
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_replay_trace_parser \
    --Mdir obj_dir -o tb_replay_trace_parser &&
./obj_dir/tb_replay_trace_parser ||
{ echo "simulation failed" >&2; exit 1; }

/* sim/tb_replay_trace_parser.sv */
`timescale 1ns/1ps

module tb_replay_trace_parser;
    import trace_geom_pkg::*;

    // array depths sized for the longest phase
    localparam int max_units = 64;
    localparam int max_bytes = max_units * 25 + 16;
    localparam int max_words = max_bytes / 8 + 2;
    // repeating gap and almost-full patterns
    localparam int pat_len = 256;

    logic       clk;
    logic       sync_rst_n;
    axi_word_t  in_data = '0;
    logic       in_empty = 1'b1;
    logic       in_rd_en;
    logic       out_almfull = 1'b0;
    unit_word_t unit_data;
    logic       unit_wr_en;

    integer seed = 32'hfd7d_eb06;

    // generated byte stream, first byte of a unit is its length in bits
    logic [7:0] stream_byte [max_bytes];
    int unit_start [max_units];
    int unit_nbytes [max_units];
    int n_units = 0;

    // input FIFO model, FWFT
    axi_word_t fifo_mem [max_words];
    int fill_level = 0;
    int rd_idx = 0;
    bit gap_pat [pat_len];
    bit almfull_pat [pat_len];

    int rx_count = 0;
    int cycle_cnt = 0;
    int cycle_limit = 200;

    replay_trace_parser u_replay_trace_parser (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_almfull (out_almfull),
        .unit_data   (unit_data),
        .unit_wr_en  (unit_wr_en)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // expected unit n, bytes placed low byte first, zero above its length
    function automatic unit_word_t expected_unit(input int n);
        unit_word_t exp_word;
        exp_word = '0;
        for (int b = 0; b < unit_nbytes[n]; b++) begin
            exp_word[b*8 +: 8] = stream_byte[unit_start[n] + b];
        end
        return exp_word;
    endfunction

    function automatic unit_word_t length_mask(input int nbits);
        unit_word_t m;
        m = '0;
        for (int i = 0; i < nbits; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    // random units packed back to back, then the pad header
    task automatic build_stream(input int count, input int min_nb, input int max_nb);
        int pos;
        int nb;
        int n_words;
        pos = 0;
        for (int u = 0; u < count; u++) begin
            nb = min_nb + int'({$random(seed)} % (max_nb - min_nb + 1));
            unit_start[u] = pos;
            unit_nbytes[u] = nb;
            stream_byte[pos] = 8'(nb * 8);
            for (int b = 1; b < nb; b++) begin
                stream_byte[pos + b] = 8'($random(seed));
            end
            pos = pos + nb;
        end
        n_units = count;
        // pad announces a full-width unit that never completes
        stream_byte[pos] = 8'(logging_unit_width);
        // a unit ending in LO needs one more word behind it
        n_words = (count > 0) ? (pos - 1) / axi_aligned_width + 2 : 0;
        for (int b = pos + 1; b < n_words * axi_aligned_width; b++) begin
            stream_byte[b] = 8'h00;
        end
        for (int w = 0; w < n_words; w++) begin
            for (int b = 0; b < axi_aligned_width; b++) begin
                fifo_mem[w][b*8 +: 8] = stream_byte[w * axi_aligned_width + b];
            end
        end
        fill_level = n_words;
    endtask

    // new stream and patterns are loaded while reset is held
    task automatic restart(input int count, input int min_nb, input int max_nb,
                           input bit gaps, input bit almfull);
        @(negedge clk);
        sync_rst_n = 1'b0;
        @(posedge clk);
        build_stream(count, min_nb, max_nb);
        for (int i = 0; i < pat_len; i++) begin
            gap_pat[i]     = gaps && (($random(seed) & 3) == 0);
            almfull_pat[i] = almfull && (($random(seed) & 1) == 1);
        end
        cycle_limit = 30 * fill_level + 200;
        repeat (3) @(negedge clk);
        sync_rst_n = 1'b1;
    endtask

    task automatic wait_units();
        wait (rx_count == n_units);
        // quiet period so a stray unit behind the pad shows up
        repeat (40) @(posedge clk);
    endtask

    // FIFO outputs and back-pressure
    always @(negedge clk) begin
        in_empty    <= (rd_idx >= fill_level) || gap_pat[cycle_cnt % pat_len];
        in_data     <= (rd_idx < fill_level) ? fifo_mem[rd_idx] : '0;
        out_almfull <= almfull_pat[cycle_cnt % pat_len];
    end

    // pop on read, with handshake checks
    always @(posedge clk) begin
        if (!sync_rst_n) begin
            rd_idx <= 0;
        end else if (in_rd_en) begin
            assert (!in_empty)
                else fail_run("DUT read from the input FIFO while it was empty");
            assert (!out_almfull)
                else fail_run($sformatf("ERROR: t=%0t read while out_almfull is high", $time));
            rd_idx <= rd_idx + 1;
        end
    end

    // compare every strobed unit against the reference
    always @(posedge clk) begin : compare_units
        unit_word_t exp_word;
        unit_word_t got_word;
        if (!sync_rst_n) begin
            rx_count <= 0;
        end else if (unit_wr_en) begin
            assert (rx_count < n_units)
                else fail_run($sformatf("extra unit written after all %0d expected units",
                                        n_units));
            if (rx_count < n_units) begin
                exp_word = expected_unit(rx_count);
                got_word = unit_data & length_mask(unit_nbytes[rx_count] * 8);
                assert (got_word == exp_word)
                    else fail_run($sformatf("ERROR: t=%0t unit %0d expected %h got %h",
                                            $time, rx_count, exp_word, got_word));
                rx_count <= rx_count + 1;
            end
        end
    end

    // watchdog, limit set per phase
    always @(posedge clk) begin
        if (!sync_rst_n) begin
            cycle_cnt <= 0;
        end else begin
            assert (cycle_cnt < cycle_limit)
                else fail_run($sformatf("timeout, units still missing after %0d cycles",
                                        cycle_cnt));
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    initial begin
        sync_rst_n = 1'b0;
        // idle, nothing in the input FIFO
        restart(0, 1, 1, 1'b0, 1'b0);
        repeat (20) begin
            @(posedge clk);
            assert (!in_rd_en && !unit_wr_en)
                else fail_run($sformatf("ERROR: t=%0t activity with an empty input FIFO",
                                        $time));
        end
        // short units, several per word
        restart(48, 1, 6, 1'b0, 1'b0);
        wait_units();
        // long units over two to four words
        restart(24, 9, 25, 1'b0, 1'b0);
        wait_units();
        // mixed lengths, almost full toggling
        restart(64, 1, 25, 1'b0, 1'b1);
        wait_units();
        // mixed lengths, gaps in the input FIFO
        restart(64, 1, 25, 1'b1, 1'b0);
        wait_units();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sim/replay_trace_parser_sva.sv */
`timescale 1ns/1ps

module replay_trace_parser_sva (
    input logic                       clk,
    input logic                       sync_rst_n,
    input logic                       in_empty,
    input logic                       in_rd_en,
    input logic                       out_almfull,
    input trace_geom_pkg::unit_word_t unit_data,
    input logic                       unit_wr_en
);
    import trace_geom_pkg::*;

    // header byte of the unit being written
    unit_len_t hdr_len;
    assign hdr_len = unit_data[offset_width-1:0];

    // no pop from an empty FIFO
    rd_not_empty: assert property (@(posedge clk) disable iff (!sync_rst_n)
        in_rd_en |-> !in_empty)
        else $error("input read while the FIFO is empty");

    // reads stop under almost full
    rd_not_almfull: assert property (@(posedge clk) disable iff (!sync_rst_n)
        in_rd_en |-> !out_almfull)
        else $error("input read while out_almfull is high");

    // written length is nonzero, fits the output word and is byte aligned
    wr_len_legal: assert property (@(posedge clk) disable iff (!sync_rst_n)
        unit_wr_en |-> (hdr_len != '0)
                       && (hdr_len <= unit_len_t'(logging_unit_width))
                       && (hdr_len[align_bits-1:0] == '0))
        else $error("unit written with an illegal length field");

endmodule

bind replay_trace_parser replay_trace_parser_sva u_sva (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .in_empty    (in_empty),
    .in_rd_en    (in_rd_en),
    .out_almfull (out_almfull),
    .unit_data   (unit_data),
    .unit_wr_en  (unit_wr_en)
);

/* design/replay_trace_parser.sv */
`timescale 1ns/1ps

module replay_trace_parser (
    input  logic                       clk,
    input  logic                       sync_rst_n,
    // input FIFO, first word fall through
    input  trace_geom_pkg::axi_word_t  in_data,
    input  logic                       in_empty,
    output logic                       in_rd_en,
    // output FIFO
    input  logic                       out_almfull,
    output trace_geom_pkg::unit_word_t unit_data,
    output logic                       unit_wr_en
);
    import trace_geom_pkg::*;

    // slices from the shift buffer, one register stage deep
    logic      slice_valid;
    axi_word_t slice_data;
    // remaining length of the unit in bits
    unit_len_t slice_len;

    // cuts the word stream into per-unit slices
    // almost full throttles reads here, slices in flight still drain
    trace_shift_buffer u_shift_buffer (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .in_rd_en    (in_rd_en),
        .slice_valid (slice_valid),
        .slice_data  (slice_data),
        .slice_len   (slice_len)
    );

    // stitches slices back into one unit and strobes it out
    unit_assembler u_assembler (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .slice_valid (slice_valid),
        .slice_data  (slice_data),
        .slice_len   (slice_len),
        .unit_data   (unit_data),
        .unit_wr_en  (unit_wr_en)
    );

endmodule

/* design/unit_assembler.sv */
`timescale 1ns/1ps

module unit_assembler (
    input  logic                       clk,
    input  logic                       sync_rst_n,
    input  logic                       slice_valid,
    input  trace_geom_pkg::axi_word_t  slice_data,
    input  trace_geom_pkg::unit_len_t  slice_len,
    output trace_geom_pkg::unit_word_t unit_data,
    output logic                       unit_wr_en
);
    import trace_geom_pkg::*;
    import trace_fsm_pkg::*;

    asm_state_t asm_state;
    asm_state_t asm_state_next;

    // total length of the unit, taken from its first slice
    unit_len_t unit_len;
    // words collected so far
    axi_cnt_t word_cnt;
    axi_cnt_t word_cnt_inc;
    // bits covered once the current slice is stored
    cover_len_t covered_bits;

    logic [num_axi-1:0][axi_width-1:0] word_slot;
    logic [num_axi*axi_width-1:0]      slot_flat;

    // a first slice that already holds the whole unit
    logic first_done;
    // a body slice that completes the unit
    logic body_done;

    assign first_done   = slice_len <= unit_len_t'(axi_width);
    assign word_cnt_inc = word_cnt + axi_cnt_t'(1);
    assign covered_bits = cover_len_t'(word_cnt_inc) * cover_len_t'(axi_width);
    assign body_done    = cover_len_t'(unit_len) <= covered_bits;

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            asm_st_wait_header: begin
                if (slice_valid) begin
                    asm_state_next = first_done ? asm_st_done : asm_st_wait_body;
                end
            end
            asm_st_wait_body: begin
                if (slice_valid && body_done) begin
                    asm_state_next = asm_st_done;
                end
            end
            asm_st_done: begin
                // slices never stall, so a new one starts the next unit here
                if (slice_valid) begin
                    asm_state_next = first_done ? asm_st_done : asm_st_wait_body;
                end else begin
                    asm_state_next = asm_st_wait_header;
                end
            end
            default: begin
                asm_state_next = asm_st_wait_header;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= asm_st_wait_header;
        end else begin
            asm_state <= asm_state_next;
        end
    end

    // counter and length
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            word_cnt <= '0;
            unit_len <= '0;
        end else if (asm_state == asm_st_wait_body) begin
            if (slice_valid) begin
                word_cnt <= word_cnt_inc;
            end
        end else if (slice_valid) begin
            // first slice of a unit carries the full length
            word_cnt <= axi_cnt_t'(1);
            unit_len <= slice_len;
        end
    end

    // word slots
    always_ff @(posedge clk) begin
        if (slice_valid) begin
            if (asm_state == asm_st_wait_body) begin
                word_slot[slot_idx_t'(word_cnt)] <= slice_data;
            end else begin
                word_slot[0] <= slice_data;
            end
        end
    end

    // slot 0 holds the header at bit 0
    assign slot_flat = word_slot;
    assign unit_data = slot_flat[logging_unit_width-1:0];

    // one strobe per finished unit
    assign unit_wr_en = (asm_state == asm_st_done);

endmodule

/* design/trace_shift_buffer.sv */
`timescale 1ns/1ps

module trace_shift_buffer (
    input  logic                      clk,
    input  logic                      sync_rst_n,
    input  trace_geom_pkg::axi_word_t in_data,
    input  logic                      in_empty,
    input  logic                      out_almfull,
    output logic                      in_rd_en,
    output logic                      slice_valid,
    output trace_geom_pkg::axi_word_t slice_data,
    output trace_geom_pkg::unit_len_t slice_len
);
    import trace_geom_pkg::*;
    import trace_fsm_pkg::*;

    // upper word is HI, lower word is LO
    logic [shift_buf_width-1:0] shift_buf;

    hi_state_t hi_state;
    hi_state_t hi_state_next;
    // word enters HI this cycle
    logic hi_in;
    // registered copy of hi_state == full
    logic hi_full;

    lo_state_t lo_state;
    lo_state_t lo_state_next;
    // registered copy of lo_state == empty
    logic lo_empty;
    // first valid byte inside LO
    aligned_off_t lo_valid_off;
    // bytes of the current unit not yet sliced out
    aligned_len_t lo_remain_len;
    aligned_len_t lo_remain_len_reg;

    // move HI down into LO
    logic hi_lo_shift;
    // issue a slice this cycle
    logic lo_out;
    axi_word_t lo_out_data;
    // this slice uses up every valid byte left in LO
    logic lo_exhaust;
    // this slice carries the rest of the unit
    logic lo_valid_satisfied;

    // read only when HI is free or is being handed down to LO
    assign in_rd_en = !in_empty && !out_almfull && (!hi_full || hi_lo_shift);
    assign hi_in = in_rd_en;

    // only slice when the data across the HI/LO boundary is contiguous
    assign lo_out = hi_full && !lo_empty;
    // refill LO when empty or when this slice drains it
    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    // 64 bits starting at the valid byte, reaching into HI as needed
    assign lo_out_data = shift_buf[int'(lo_valid_off) * packet_alignment +: axi_width];

    // header length is decoded straight from the slice in header state
    always_comb begin
        case (lo_state)
            lo_st_header: begin
                lo_remain_len = lo_out_data[align_bits +: aligned_offset_width];
            end
            lo_st_body: begin
                lo_remain_len = lo_remain_len_reg;
            end
            default: begin
                lo_remain_len = '0;
            end
        endcase
    end

    // widened so that a long unit at a high offset cannot wrap
    assign lo_exhaust = (exhaust_width'(lo_remain_len) + exhaust_width'(lo_valid_off))
                        >= exhaust_width'(axi_aligned_width);
    assign lo_valid_satisfied = lo_remain_len <= aligned_len_t'(axi_aligned_width);

    // HI state machine
    always_comb begin
        hi_state_next = hi_state;
        case (hi_state)
            hi_st_empty: begin
                // load
                if (hi_in) begin
                    hi_state_next = hi_st_full;
                end
            end
            hi_st_full: begin
                // unload without a new word behind it
                // shift together with hi_in is a flow and stays full
                if (hi_lo_shift && !hi_in) begin
                    hi_state_next = hi_st_empty;
                end
            end
            default: begin
                hi_state_next = hi_st_empty;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= hi_st_empty;
            hi_full  <= 1'b0;
        end else begin
            hi_state <= hi_state_next;
            hi_full  <= (hi_state_next == hi_st_full);
        end
    end

    // LO state machine
    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            lo_st_empty: begin
                if (hi_lo_shift) begin
                    lo_state_next = lo_st_header;
                end
            end
            lo_st_header, lo_st_body: begin
                if (hi_lo_shift) begin
                    // LO drained, the unit either ends here or continues in the new LO
                    lo_state_next = lo_valid_satisfied ? lo_st_header : lo_st_body;
                end else if (lo_out && !lo_exhaust) begin
                    // unit ended inside LO so the next header follows it
                    lo_state_next = lo_st_header;
                end
            end
            default: begin
                lo_state_next = lo_st_empty;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= lo_st_empty;
            lo_empty <= 1'b1;
        end else begin
            lo_state <= lo_state_next;
            lo_empty <= (lo_state_next == lo_st_empty);
        end
    end

    // valid offset moves past the finished unit
    // modulo the word size, which also covers the wrap into the new LO
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_valid_off <= '0;
        end else if (lo_state == lo_st_empty) begin
            lo_valid_off <= '0;
        end else if (hi_lo_shift) begin
            // a continuing unit keeps its offset in the new LO
            if (lo_valid_satisfied) begin
                lo_valid_off <= lo_valid_off + lo_remain_len[axi_aligned_offset_width-1:0];
            end
        end else if (lo_out && !lo_exhaust) begin
            lo_valid_off <= lo_valid_off + lo_remain_len[axi_aligned_offset_width-1:0];
        end
    end

    // remaining length after one full word was sliced out
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_remain_len_reg <= '0;
        end else if (hi_lo_shift && !lo_valid_satisfied) begin
            lo_remain_len_reg <= lo_remain_len - aligned_len_t'(axi_aligned_width);
        end
    end

    // two-word data path
    always_ff @(posedge clk) begin
        if (hi_in) begin
            shift_buf[axi_width +: axi_width] <= in_data;
        end
        if (hi_lo_shift) begin
            shift_buf[0 +: axi_width] <= shift_buf[axi_width +: axi_width];
        end
    end

    // register barrier towards the assembler
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            slice_valid <= 1'b0;
        end else begin
            slice_valid <= lo_out;
        end
    end

    always_ff @(posedge clk) begin
        slice_data <= lo_out_data;
        // bytes back to bits
        slice_len  <= {lo_remain_len, {align_bits{1'b0}}};
    end

endmodule

/* design/trace_fsm_pkg.sv */
package trace_fsm_pkg;

    // HI half of the shift buffer
    typedef enum logic {
        hi_st_empty,
        hi_st_full
    } hi_state_t;

    // LO half of the shift buffer
    // header means the valid offset points at a length byte
    typedef enum logic [1:0] {
        lo_st_empty,
        lo_st_header,
        lo_st_body
    } lo_state_t;

    // unit assembler
    typedef enum logic [1:0] {
        asm_st_wait_header,
        asm_st_wait_body,
        asm_st_done
    } asm_state_t;

endpackage

/* design/trace_geom_pkg.sv */
package trace_geom_pkg;

    // input side, one FWFT word per read
    localparam int axi_width = 64;
    // units start on byte boundaries
    localparam int packet_alignment = 8;
    // output side, one complete unit per write
    localparam int logging_unit_width = 200;

    // header must hold lengths up to the full unit width
    localparam int offset_width = $clog2(logging_unit_width + 1);
    localparam int align_bits = $clog2(packet_alignment);
    // unit length counted in bytes
    localparam int aligned_offset_width = offset_width - align_bits;
    // bytes per input word and the byte index inside it
    localparam int axi_aligned_width = axi_width / packet_alignment;
    localparam int axi_aligned_offset_width = $clog2(axi_aligned_width);
    // input words needed to cover one output unit
    localparam int num_axi = (logging_unit_width - 1) / axi_width + 1;

    // two-word shift buffer, HI on top of LO
    localparam int shift_buf_width = 2 * axi_width;
    // room for remaining length plus offset without overflow
    localparam int exhaust_width = aligned_offset_width + axi_aligned_offset_width;
    // assembler word counter runs up to num_axi
    localparam int axi_cnt_width = $clog2(num_axi + 1);
    localparam int slot_idx_width = $clog2(num_axi);

    typedef logic [axi_width-1:0]                axi_word_t;
    typedef logic [logging_unit_width-1:0]       unit_word_t;
    typedef logic [offset_width-1:0]             unit_len_t;
    typedef logic [aligned_offset_width-1:0]     aligned_len_t;
    typedef logic [axi_aligned_offset_width-1:0] aligned_off_t;
    typedef logic [axi_cnt_width-1:0]            axi_cnt_t;
    typedef logic [slot_idx_width-1:0]           slot_idx_t;
    // one bit wider than a length so that num_axi words fit
    typedef logic [offset_width:0]               cover_len_t;

endpackage
